// ==== Bender.yml ====
package:
  name: aes_fe

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/aes_fe_pkg.sv
      - hdl/aes_fe_req_mux.sv
      - hdl/aes_fe_regs.sv
      - hdl/aes_fe_key_loader.sv
      - hdl/aes_fe_entropy.sv
      - hdl/aes_fe_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - dv/aes_fe_tb.sv

// ==== dv/aes_fe_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aes_fe_config.svh"

module aes_fe_tb;
  import aes_fe_pkg::*;

  localparam int MAX_OPS    = 128;
  localparam int KV_TIMEOUT = 20;

  logic        clk;
  logic        reset_n;
  logic        host_dv_i;
  logic        host_write_i;
  addr_t       host_addr_i;
  word_t       host_wdata_i;
  word_t       host_rdata_o;
  logic        host_err_o;
  logic        dma_dv_i;
  logic        dma_write_i;
  addr_t       dma_addr_i;
  word_t       dma_wdata_i;
  word_t       dma_rdata_o;
  logic        dma_err_o;
  logic        engine_idle_i;
  logic        engine_input_ready_i;
  block_t      data_out_i;
  block_t      data_in_o;
  key_t        key_o;
  logic        key_valid_o;
  logic        entropy_req_i;
  logic        entropy_ack_o;
  word_t       entropy_o;
  logic        kv_rd_req_o;
  kv_entry_t   kv_rd_entry_o;
  logic        kv_beat_valid_i;
  logic [2:0]  kv_beat_offset_i;
  word_t       kv_beat_data_i;
  logic        kv_done_i;
  logic        kv_err_i;
  logic        zeroize_i;
  logic        busy_o;

  // Three words per vector line for op, addr and data
  logic [31:0] vec_mem [0:3*MAX_OPS-1];
  logic [15:0] lfsr_q;
  key_t        exp_key;
  int          n_ops;

  aes_fe_top aes_fe_top_i (.*);

  always #4 clk = ~clk;

  // ======================================================================
  // Helpers
  // ======================================================================
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0d ns: %s is %08h, expected %08h", $time, what, got, exp));
    end
  endtask

  task automatic check_key(input string what, input key_t got, input key_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0d ns: %s is %064h, expected %064h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0d ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  function automatic word_t reverse_bytes(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Galois LFSR for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hb400;
    end
    return s >> 1;
  endfunction

  task automatic rand_word(output word_t w);
    for (int i = 0; i < 32; i++) begin
      w[i] = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Single-port access while the other port stays quiet
  task automatic bus_access(input logic use_dma, input logic wr, input addr_t a,
                            input word_t d, output word_t rdata);
    @(negedge clk);
    if (use_dma) begin
      dma_dv_i    = 1'b1;
      dma_write_i = wr;
      dma_addr_i  = a;
      dma_wdata_i = d;
    end else begin
      host_dv_i    = 1'b1;
      host_write_i = wr;
      host_addr_i  = a;
      host_wdata_i = d;
    end
    #2;
    check_bit("host_err_o", host_err_o, 1'b0);
    check_bit("dma_err_o", dma_err_o, 1'b0);
    if (use_dma) begin
      check_word("host_rdata_o without request", host_rdata_o, '0);
      rdata = dma_rdata_o;
    end else begin
      check_word("dma_rdata_o without request", dma_rdata_o, '0);
      rdata = host_rdata_o;
    end
    @(negedge clk);
    host_dv_i    = 1'b0;
    host_write_i = 1'b0;
    dma_dv_i     = 1'b0;
    dma_write_i  = 1'b0;
  endtask

  task automatic wait_kv_request(input kv_entry_t entry);
    int waited;
    waited = 0;
    while (kv_rd_req_o !== 1'b1) begin
      if (waited == KV_TIMEOUT) begin
        abort_run("Timed out waiting for kv_rd_req_o after the key-read control write");
      end
      @(negedge clk);
      waited++;
    end
    check_word("kv_rd_entry_o", word_t'(kv_rd_entry_o), word_t'(entry));
    check_bit("busy_o during key read", busy_o, 1'b1);
    @(negedge clk);
    check_bit("kv_rd_req_o after one cycle", kv_rd_req_o, 1'b0);
  endtask

  task automatic draw_entropy(output word_t w);
    @(negedge clk);
    entropy_req_i = 1'b1;
    #2;
    check_bit("entropy_ack_o", entropy_ack_o, 1'b1);
    w = entropy_o;
    @(negedge clk);
    entropy_req_i = 1'b0;
  endtask

  task automatic write_seed(input int count);
    word_t w;
    word_t rd;
    for (int i = 0; i < count; i++) begin
      rand_word(w);
      bus_access(1'b0, 1'b1, addr_t'(`AES_FE_REG_SEED_BASE + 4 * i), w, rd);
    end
  endtask

  // Same seed twice gives the same stream and a partial seed keeps it running
  task automatic check_reseed();
    word_t       ref_seq [8];
    word_t       w;
    logic [15:0] lfsr_saved;
    check_bit("entropy_ack_o without request", entropy_ack_o, 1'b0);
    lfsr_saved = lfsr_q;
    write_seed(`AES_FE_SEED_WORDS);
    for (int i = 0; i < 8; i++) begin
      draw_entropy(ref_seq[i]);
    end
    lfsr_q = lfsr_saved;
    write_seed(`AES_FE_SEED_WORDS);
    for (int i = 0; i < 4; i++) begin
      draw_entropy(w);
      check_word("entropy after reseed", w, ref_seq[i]);
    end
    write_seed(`AES_FE_SEED_WORDS - 1);
    for (int i = 4; i < 8; i++) begin
      draw_entropy(w);
      check_word("entropy after partial seed", w, ref_seq[i]);
    end
  endtask

  // ======================================================================
  // Vector dispatch
  // ======================================================================
  task automatic run_op(input logic [7:0] op, input addr_t a, input word_t d);
    word_t w;
    word_t rd;
    case (op)
      8'h01: bus_access(1'b0, 1'b1, a, d, rd);
      8'h02: begin
        bus_access(1'b0, 1'b0, a, '0, rd);
        check_word($sformatf("host read of %03h", a), rd, d);
      end
      8'h03: bus_access(1'b1, 1'b1, a, d, rd);
      8'h04: begin
        bus_access(1'b1, 1'b0, a, '0, rd);
        check_word($sformatf("DMA read of %03h", a), rd, d);
      end
      8'h05: begin
        @(negedge clk);
        host_dv_i   = 1'b1;
        host_addr_i = `AES_FE_REG_NAME;
        dma_dv_i    = 1'b1;
        dma_addr_i  = a;
        #2;
        check_bit("host_err_o on collision", host_err_o, 1'b1);
        check_bit("dma_err_o on collision", dma_err_o, 1'b1);
        check_word("host_rdata_o on collision", host_rdata_o, d);
        check_word("dma_rdata_o on collision", dma_rdata_o, d);
        @(negedge clk);
        host_dv_i = 1'b0;
        dma_dv_i  = 1'b0;
      end
      8'h06: begin
        @(negedge clk);
        data_out_i[a[1:0]] = d;
      end
      8'h07: begin
        #2;
        check_word("data_in_o word", data_in_o[a[1:0]], d);
      end
      8'h08: begin
        rand_word(w);
        bus_access(1'b0, 1'b1, a, w, rd);
        bus_access(1'b0, 1'b0, a, '0, rd);
        check_word("data-in readback", rd, w);
        check_word("data_in_o word", data_in_o[a[3:2]], d[0] ? reverse_bytes(w) : w);
      end
      8'h09: wait_kv_request(kv_entry_t'(d));
      8'h0a: begin
        @(negedge clk);
        kv_beat_valid_i  = 1'b1;
        kv_beat_offset_i = a[2:0];
        kv_beat_data_i   = d;
        @(negedge clk);
        kv_beat_valid_i = 1'b0;
      end
      8'h0b: begin
        @(negedge clk);
        kv_done_i = 1'b1;
        @(negedge clk);
        kv_done_i = 1'b0;
      end
      8'h0c: begin
        @(negedge clk);
        kv_err_i = 1'b1;
        @(negedge clk);
        kv_err_i = 1'b0;
      end
      8'h0d: begin
        @(negedge clk);
        zeroize_i = 1'b1;
        @(negedge clk);
        zeroize_i = 1'b0;
      end
      8'h0e: exp_key[a[2:0]] = d;
      8'h0f: begin
        #2;
        check_key("key_o", key_o, exp_key);
        check_bit("key_valid_o", key_valid_o, d[0]);
        exp_key = '0;
      end
      8'h10: begin
        #2;
        check_bit("busy_o", busy_o, d[0]);
      end
      8'h11: check_reseed();
      default: abort_run($sformatf("Unknown vector op %02h in vector %0d", op, n_ops + 1));
    endcase
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin
    clk                  = 1'b0;
    reset_n              = 1'b0;
    host_dv_i            = 1'b0;
    host_write_i         = 1'b0;
    host_addr_i          = '0;
    host_wdata_i         = '0;
    dma_dv_i             = 1'b0;
    dma_write_i          = 1'b0;
    dma_addr_i           = '0;
    dma_wdata_i          = '0;
    engine_idle_i        = 1'b1;
    engine_input_ready_i = 1'b1;
    data_out_i           = '0;
    entropy_req_i        = 1'b0;
    kv_beat_valid_i      = 1'b0;
    kv_beat_offset_i     = '0;
    kv_beat_data_i       = '0;
    kv_done_i            = 1'b0;
    kv_err_i             = 1'b0;
    zeroize_i            = 1'b0;
    lfsr_q               = 16'd14;
    exp_key              = '0;
    n_ops                = 0;

    $readmemh("dv/aes_fe_vectors.txt", vec_mem);

    repeat (2) @(negedge clk);
    reset_n = 1'b1;
    #2;
    check_bit("kv_rd_req_o after reset", kv_rd_req_o, 1'b0);
    check_bit("key_valid_o after reset", key_valid_o, 1'b0);
    check_bit("entropy_ack_o after reset", entropy_ack_o, 1'b0);
    check_bit("busy_o after reset", busy_o, 1'b0);
    check_key("key_o after reset", key_o, '0);
    for (int i = 0; i < `AES_FE_DATA_WORDS; i++) begin
      check_word("data_in_o after reset", data_in_o[i], '0);
    end

    // ff marks the end of the list
    while ((n_ops < MAX_OPS) && !$isunknown(vec_mem[3*n_ops]) &&
           (vec_mem[3*n_ops] != 32'hff)) begin
      run_op(vec_mem[3*n_ops][7:0], vec_mem[3*n_ops+1][11:0], vec_mem[3*n_ops+2]);
      n_ops++;
    end

    if (n_ops == 0) begin
      abort_run("No vectors could be read from dv/aes_fe_vectors.txt");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== dv/aes_fe_vectors.txt ====
// Columns: op addr data, all hex; ff ends the list
// 01/02 host wr/rd, 03/04 DMA wr/rd, 05 collision, 06 data_out word, 07 data_in_o word
// 08 random data-in (data 1 = swap on), 09 key request (data = entry), 0a beat,
// 0b done, 0c error, 0d zeroize, 0e expected key dword, 0f key check, 10 busy, 11 reseed
02 000 00616573
04 004 00312e30
01 050 11223344
02 050 11223344
07 000 11223344
03 054 0badf00d
04 054 0badf00d
06 001 a1b2c3d4
02 064 a1b2c3d4
08 058 00000000
// Endian swap on the data windows only
01 008 00000001
02 008 00000001
01 05c 55667788
02 05c 55667788
07 003 88776655
04 064 d4c3b2a1
08 050 00000001
01 008 00000000
05 004 00312e30
// Full key read from slot 5, rewrite while busy is dropped
01 00c 0000000b
09 000 00000005
10 000 00000001
02 010 00000000
01 00c 0000003f
02 00c 0000000a
0a 000 00010203
0a 001 04050607
0a 002 08090a0b
0a 003 0c0d0e0f
0a 004 10111213
0a 005 14151617
0a 006 18191a1b
0a 007 1c1d1e1f
0b 000 00000000
0e 000 03020100
0e 001 07060504
0e 002 0b0a0908
0e 003 0f0e0d0c
0e 004 13121110
0e 005 17161514
0e 006 1b1a1918
0e 007 1f1e1d1c
0f 000 00000001
02 010 00000003
10 000 00000000
// Short key from slot 3, then a failed read
01 00c 00000007
09 000 00000003
0a 000 deadbeef
0a 001 cafebabe
0a 002 01234567
0a 003 89abcdef
0b 000 00000000
0e 000 efbeadde
0e 001 bebafeca
0e 002 67452301
0e 003 efcdab89
0f 000 00000001
0c 000 00000000
0f 000 00000000
02 010 00000007
// Slot 1, then zeroize
01 00c 00000003
09 000 00000001
0a 000 cafef00d
0b 000 00000000
0e 000 0df0feca
0f 000 00000001
0d 000 00000000
0f 000 00000000
11 000 00000000
ff 000 00000000

// ==== hdl/aes_fe_config.svh ====
`ifndef AES_FE_CONFIG_SVH
`define AES_FE_CONFIG_SVH

// ======================================================================
// Bus and identity
// ======================================================================
`define AES_FE_ADDR_W 12
// "aes" and "1.0" in ASCII
`define AES_FE_NAME 32'h0061_6573
`define AES_FE_VERSION 32'h0031_2e30

// ======================================================================
// Register map
// ======================================================================
`define AES_FE_REG_NAME 12'h000
`define AES_FE_REG_VERSION 12'h004
`define AES_FE_REG_CTRL0 12'h008
`define AES_FE_REG_KV_RD_CTRL 12'h00c
`define AES_FE_REG_KV_RD_STATUS 12'h010

// Seed words sit back to back from the seed base
`define AES_FE_REG_SEED_BASE 12'h020
`define AES_FE_SEED_WORDS 9
`define AES_FE_SEED_IDX_W $clog2(`AES_FE_SEED_WORDS)

// Data windows, each one 128-bit block wide
`define AES_FE_REG_DIN_BASE 12'h050
`define AES_FE_REG_DOUT_BASE 12'h060
`define AES_FE_DATA_WORDS 4

// ======================================================================
// Keyvault
// ======================================================================
`define AES_FE_KEY_DWORDS 8
`define AES_FE_KV_ENTRY_W 5

`endif

// ==== hdl/aes_fe_entropy.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aes_fe_config.svh"

module aes_fe_entropy (
  input  wire                           clk,
  input  wire                           reset_n,
  input  wire                           seed_wr_i,
  input  wire [`AES_FE_SEED_IDX_W-1:0]  seed_idx_i,
  input  wire aes_fe_pkg::word_t        seed_wdata_i,
  input  wire                           entropy_req_i,
  output logic                          entropy_ack_o,
  output aes_fe_pkg::word_t             entropy_o
);
  import aes_fe_pkg::*;

  // Netlist constant state until firmware provides a seed
  localparam seed_t STATE_RST = {9{32'h5a3c_96e1}};

  seed_t                         seed_q;
  logic [`AES_FE_SEED_WORDS-1:0] seed_mask_q;
  logic                          seed_full;
  seed_t                         state_q;
  seed_t                         ks_state;
  word_t                         ks_word;
  logic                          t1;
  logic                          t2;
  logic                          t3;

  // ======================================================================
  // Seed tracking
  // ======================================================================
  always_ff @(posedge clk) begin
    if (seed_wr_i && (seed_idx_i < `AES_FE_SEED_WORDS)) begin
      seed_q[32*seed_idx_i +: 32] <= seed_wdata_i;
    end
  end

  // Reseed once every word was written at least once, then start over
  assign seed_full = &seed_mask_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      seed_mask_q <= '0;
    end else if (seed_full) begin
      seed_mask_q <= '0;
    end else if (seed_wr_i && (seed_idx_i < `AES_FE_SEED_WORDS)) begin
      seed_mask_q[seed_idx_i] <= 1'b1;
    end
  end

  // ======================================================================
  // Trivium, 32 rounds unrolled per cycle
  // ======================================================================
  always_comb begin
    ks_state = state_q;
    for (int i = 0; i < 32; i++) begin
      t1 = ks_state[65] ^ ks_state[92];
      t2 = ks_state[161] ^ ks_state[176];
      t3 = ks_state[242] ^ ks_state[287];
      ks_word[i] = t1 ^ t2 ^ t3;
      t1 = t1 ^ (ks_state[90] & ks_state[91]) ^ ks_state[170];
      t2 = t2 ^ (ks_state[174] & ks_state[175]) ^ ks_state[263];
      t3 = t3 ^ (ks_state[285] & ks_state[286]) ^ ks_state[68];
      // Three shift registers of 93, 84 and 111 bits
      ks_state = {ks_state[286:177], t2, ks_state[175:93], t1, ks_state[91:0], t3};
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= STATE_RST;
    end else if (seed_full) begin
      state_q <= seed_q;
    end else if (entropy_req_i) begin
      state_q <= ks_state;
    end
  end

  assign entropy_ack_o = entropy_req_i;
  assign entropy_o     = ks_word;

endmodule

`default_nettype wire

// ==== hdl/aes_fe_key_loader.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aes_fe_config.svh"

module aes_fe_key_loader (
  input  wire                    clk,
  input  wire                    reset_n,
  input  wire                    zeroize_i,
  input  wire                    kv_rd_start_i,
  input  wire                    kv_beat_valid_i,
  input  wire [2:0]              kv_beat_offset_i,
  input  wire aes_fe_pkg::word_t kv_beat_data_i,
  input  wire                    kv_done_i,
  input  wire                    kv_err_i,
  output aes_fe_pkg::key_t       key_o,
  output logic                   key_valid_o
);
  import aes_fe_pkg::*;

  key_t key_buf_q;

  // ======================================================================
  // Beat assembly
  // ======================================================================
  // Each beat lands byte-reversed at its dword, and every dword above it
  // is cleared so a short key never keeps stale upper words
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key_buf_q <= '0;
    end else if (zeroize_i) begin
      key_buf_q <= '0;
    end else if (kv_beat_valid_i) begin
      for (int d = 0; d < `AES_FE_KEY_DWORDS; d++) begin
        if (d == kv_beat_offset_i) begin
          key_buf_q[d] <= byte_swap(kv_beat_data_i);
        end else if (d > kv_beat_offset_i) begin
          key_buf_q[d] <= '0;
        end
      end
    end
  end

  // ======================================================================
  // Key to engine
  // ======================================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key_o       <= '0;
      key_valid_o <= 1'b0;
    end else if (kv_rd_start_i || kv_err_i || zeroize_i) begin
      // New request, failed read or zeroize invalidates the key
      key_o       <= '0;
      key_valid_o <= 1'b0;
    end else if (kv_done_i) begin
      key_o       <= key_buf_q;
      key_valid_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/aes_fe_pkg.sv ====
`default_nettype none

`include "aes_fe_config.svh"

package aes_fe_pkg;

  typedef logic [31:0] word_t;
  typedef logic [`AES_FE_ADDR_W-1:0] addr_t;
  typedef logic [`AES_FE_KEY_DWORDS-1:0][31:0] key_t;
  typedef logic [`AES_FE_DATA_WORDS-1:0][31:0] block_t;
  typedef logic [287:0] seed_t;
  typedef logic [`AES_FE_KV_ENTRY_W-1:0] kv_entry_t;

  // Key-read control fields, read_en in bit 0
  typedef struct packed {
    logic [25:0] rsvd;
    kv_entry_t   read_entry;
    logic        read_en;
  } kv_rd_ctrl_t;

  typedef union packed {
    word_t       raw;
    kv_rd_ctrl_t f;
  } kv_rd_ctrl_u;

  // Reverse the four bytes of a word
  function automatic word_t byte_swap(word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

endpackage

`default_nettype wire

// ==== hdl/aes_fe_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aes_fe_config.svh"

module aes_fe_regs (
  input  wire                           clk,
  input  wire                           reset_n,
  input  wire                           req_dv_i,
  input  wire                           req_write_i,
  input  wire aes_fe_pkg::addr_t        req_addr_i,
  input  wire aes_fe_pkg::word_t        req_wdata_i,
  output aes_fe_pkg::word_t             regs_rdata_o,
  input  wire                           engine_idle_i,
  input  wire                           engine_input_ready_i,
  input  wire aes_fe_pkg::block_t       data_out_i,
  input  wire                           kv_done_i,
  input  wire                           kv_err_i,
  output logic                          endian_swap_o,
  output aes_fe_pkg::block_t            data_in_o,
  output logic                          seed_wr_o,
  output logic [`AES_FE_SEED_IDX_W-1:0] seed_idx_o,
  output aes_fe_pkg::word_t             seed_wdata_o,
  output logic                          kv_rd_start_o,
  output logic                          kv_rd_req_o,
  output aes_fe_pkg::kv_entry_t         kv_rd_entry_o,
  output logic                          busy_o
);
  import aes_fe_pkg::*;

  word_t       ctrl0_q;
  kv_rd_ctrl_u kv_rd_ctrl_q;
  kv_rd_ctrl_u kv_wr_view;
  block_t      data_in_q;
  logic        kv_ready_q;
  logic        kv_valid_q;
  logic        kv_error_q;
  logic        wr_en;
  logic        kv_ctrl_wr;
  logic        din_hit;
  logic        dout_hit;
  logic        seed_hit;
  logic [1:0]  din_idx;
  logic [1:0]  dout_idx;

  // ======================================================================
  // Address decode
  // ======================================================================
  assign wr_en = req_dv_i & req_write_i;

  assign din_hit  = (req_addr_i >= `AES_FE_REG_DIN_BASE) &&
                    (req_addr_i < `AES_FE_REG_DIN_BASE + 4 * `AES_FE_DATA_WORDS);
  assign dout_hit = (req_addr_i >= `AES_FE_REG_DOUT_BASE) &&
                    (req_addr_i < `AES_FE_REG_DOUT_BASE + 4 * `AES_FE_DATA_WORDS);
  assign seed_hit = (req_addr_i >= `AES_FE_REG_SEED_BASE) &&
                    (req_addr_i < `AES_FE_REG_SEED_BASE + 4 * `AES_FE_SEED_WORDS);

  assign din_idx  = 2'((req_addr_i - `AES_FE_REG_DIN_BASE) >> 2);
  assign dout_idx = 2'((req_addr_i - `AES_FE_REG_DOUT_BASE) >> 2);

  // Seed words pass straight through to the entropy block
  assign seed_wr_o    = wr_en & seed_hit;
  assign seed_idx_o   = `AES_FE_SEED_IDX_W'((req_addr_i - `AES_FE_REG_SEED_BASE) >> 2);
  assign seed_wdata_o = req_wdata_i;

  // ======================================================================
  // Storage
  // ======================================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ctrl0_q   <= '0;
      data_in_q <= '0;
    end else if (wr_en) begin
      if (req_addr_i == `AES_FE_REG_CTRL0) begin
        ctrl0_q <= req_wdata_i;
      end
      if (din_hit) begin
        data_in_q[din_idx] <= req_wdata_i;
      end
    end
  end

  assign endian_swap_o = ctrl0_q[0];
  assign data_in_o     = data_in_q;

  // ======================================================================
  // Key-read control and status
  // ======================================================================
  // Control may only change while the engine is idle and no read is running
  assign kv_wr_view.raw = req_wdata_i;
  assign kv_ctrl_wr = wr_en && (req_addr_i == `AES_FE_REG_KV_RD_CTRL) &&
                      engine_idle_i && engine_input_ready_i && kv_ready_q;

  // read_en lives for a single cycle and forms the start pulse
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      kv_rd_ctrl_q <= '0;
    end else if (kv_ctrl_wr) begin
      kv_rd_ctrl_q.raw <= req_wdata_i;
    end else begin
      kv_rd_ctrl_q.f.read_en <= 1'b0;
    end
  end

  assign kv_rd_start_o = kv_rd_ctrl_q.f.read_en;
  assign kv_rd_entry_o = kv_rd_ctrl_q.f.read_entry;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      kv_ready_q  <= 1'b1;
      kv_valid_q  <= 1'b0;
      kv_error_q  <= 1'b0;
      kv_rd_req_o <= 1'b0;
    end else begin
      kv_rd_req_o <= kv_rd_start_o;
      if (kv_ctrl_wr && kv_wr_view.f.read_en) begin
        kv_ready_q <= 1'b0;
      end else if (kv_done_i || kv_err_i) begin
        kv_ready_q <= 1'b1;
      end
      // A new request drops the old result
      if (kv_rd_start_o) begin
        kv_valid_q <= 1'b0;
        kv_error_q <= 1'b0;
      end else begin
        if (kv_done_i) kv_valid_q <= 1'b1;
        if (kv_err_i) kv_error_q <= 1'b1;
      end
    end
  end

  assign busy_o = ~engine_idle_i | ~kv_ready_q;

  // ======================================================================
  // Read data
  // ======================================================================
  always_comb begin
    regs_rdata_o = '0;
    case (req_addr_i)
      `AES_FE_REG_NAME:         regs_rdata_o = `AES_FE_NAME;
      `AES_FE_REG_VERSION:      regs_rdata_o = `AES_FE_VERSION;
      `AES_FE_REG_CTRL0:        regs_rdata_o = ctrl0_q;
      `AES_FE_REG_KV_RD_CTRL:   regs_rdata_o = kv_rd_ctrl_q.raw;
      `AES_FE_REG_KV_RD_STATUS: regs_rdata_o = {29'd0, kv_error_q, kv_valid_q, kv_ready_q};
      default: begin
        // Seed words are write-only and read as zero
        if (din_hit) begin
          regs_rdata_o = data_in_q[din_idx];
        end else if (dout_hit) begin
          regs_rdata_o = data_out_i[dout_idx];
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/aes_fe_req_mux.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aes_fe_config.svh"

module aes_fe_req_mux (
  input  wire                    host_dv_i,
  input  wire                    host_write_i,
  input  wire aes_fe_pkg::addr_t host_addr_i,
  input  wire aes_fe_pkg::word_t host_wdata_i,
  output aes_fe_pkg::word_t      host_rdata_o,
  output logic                   host_err_o,
  input  wire                    dma_dv_i,
  input  wire                    dma_write_i,
  input  wire aes_fe_pkg::addr_t dma_addr_i,
  input  wire aes_fe_pkg::word_t dma_wdata_i,
  output aes_fe_pkg::word_t      dma_rdata_o,
  output logic                   dma_err_o,
  input  wire                    endian_swap_i,
  input  wire aes_fe_pkg::word_t regs_rdata_i,
  output logic                   req_dv_o,
  output logic                   req_write_o,
  output aes_fe_pkg::addr_t      req_addr_o,
  output aes_fe_pkg::word_t      req_wdata_o
);
  import aes_fe_pkg::*;

  logic  collision;
  logic  din_hit;
  logic  dout_hit;
  logic  swap_en;
  word_t wdata_sel;
  word_t rdata_post;

  // Both ports at once is a software error, reported on both
  assign collision  = host_dv_i & dma_dv_i;
  assign host_err_o = collision;
  assign dma_err_o  = collision;

  // DMA wins address and data on a collision
  assign req_dv_o    = host_dv_i | dma_dv_i;
  assign req_write_o = dma_dv_i ? dma_write_i : host_write_i;
  assign req_addr_o  = dma_dv_i ? dma_addr_i : host_addr_i;
  assign wdata_sel   = dma_dv_i ? dma_wdata_i : host_wdata_i;

  assign din_hit  = (req_addr_o >= `AES_FE_REG_DIN_BASE) &&
                    (req_addr_o < `AES_FE_REG_DIN_BASE + 4 * `AES_FE_DATA_WORDS);
  assign dout_hit = (req_addr_o >= `AES_FE_REG_DOUT_BASE) &&
                    (req_addr_o < `AES_FE_REG_DOUT_BASE + 4 * `AES_FE_DATA_WORDS);

  // Only the data windows are byte swapped, control registers never
  assign swap_en = req_dv_o & endian_swap_i & (din_hit | dout_hit);

  assign req_wdata_o = swap_en ? byte_swap(wdata_sel) : wdata_sel;
  assign rdata_post  = swap_en ? byte_swap(regs_rdata_i) : regs_rdata_i;

  assign host_rdata_o = host_dv_i ? rdata_post : '0;
  assign dma_rdata_o  = dma_dv_i ? rdata_post : '0;

endmodule

`default_nettype wire

// ==== hdl/aes_fe_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "aes_fe_config.svh"

module aes_fe_top (
  input  wire                        clk,
  input  wire                        reset_n,
  // Host port
  input  wire                        host_dv_i,
  input  wire                        host_write_i,
  input  wire aes_fe_pkg::addr_t     host_addr_i,
  input  wire aes_fe_pkg::word_t     host_wdata_i,
  output aes_fe_pkg::word_t          host_rdata_o,
  output logic                       host_err_o,
  // DMA port
  input  wire                        dma_dv_i,
  input  wire                        dma_write_i,
  input  wire aes_fe_pkg::addr_t     dma_addr_i,
  input  wire aes_fe_pkg::word_t     dma_wdata_i,
  output aes_fe_pkg::word_t          dma_rdata_o,
  output logic                       dma_err_o,
  // Engine
  input  wire                        engine_idle_i,
  input  wire                        engine_input_ready_i,
  input  wire aes_fe_pkg::block_t    data_out_i,
  output aes_fe_pkg::block_t         data_in_o,
  output aes_fe_pkg::key_t           key_o,
  output logic                       key_valid_o,
  input  wire                        entropy_req_i,
  output logic                       entropy_ack_o,
  output aes_fe_pkg::word_t          entropy_o,
  // Keyvault
  output logic                       kv_rd_req_o,
  output aes_fe_pkg::kv_entry_t      kv_rd_entry_o,
  input  wire                        kv_beat_valid_i,
  input  wire [2:0]                  kv_beat_offset_i,
  input  wire aes_fe_pkg::word_t     kv_beat_data_i,
  input  wire                        kv_done_i,
  input  wire                        kv_err_i,
  input  wire                        zeroize_i,
  output logic                       busy_o
);
  import aes_fe_pkg::*;

  logic                          req_dv;
  logic                          req_write;
  addr_t                         req_addr;
  word_t                         req_wdata;
  word_t                         regs_rdata;
  logic                          endian_swap;
  logic                          seed_wr;
  logic [`AES_FE_SEED_IDX_W-1:0] seed_idx;
  word_t                         seed_wdata;
  logic                          kv_rd_start;

  aes_fe_req_mux u_req_mux (
    .host_dv_i    (host_dv_i),
    .host_write_i (host_write_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_rdata_o (host_rdata_o),
    .host_err_o   (host_err_o),
    .dma_dv_i     (dma_dv_i),
    .dma_write_i  (dma_write_i),
    .dma_addr_i   (dma_addr_i),
    .dma_wdata_i  (dma_wdata_i),
    .dma_rdata_o  (dma_rdata_o),
    .dma_err_o    (dma_err_o),
    .endian_swap_i(endian_swap),
    .regs_rdata_i (regs_rdata),
    .req_dv_o     (req_dv),
    .req_write_o  (req_write),
    .req_addr_o   (req_addr),
    .req_wdata_o  (req_wdata)
  );

  aes_fe_regs u_regs (
    .clk                 (clk),
    .reset_n             (reset_n),
    .req_dv_i            (req_dv),
    .req_write_i         (req_write),
    .req_addr_i          (req_addr),
    .req_wdata_i         (req_wdata),
    .regs_rdata_o        (regs_rdata),
    .engine_idle_i       (engine_idle_i),
    .engine_input_ready_i(engine_input_ready_i),
    .data_out_i          (data_out_i),
    .kv_done_i           (kv_done_i),
    .kv_err_i            (kv_err_i),
    .endian_swap_o       (endian_swap),
    .data_in_o           (data_in_o),
    .seed_wr_o           (seed_wr),
    .seed_idx_o          (seed_idx),
    .seed_wdata_o        (seed_wdata),
    .kv_rd_start_o       (kv_rd_start),
    .kv_rd_req_o         (kv_rd_req_o),
    .kv_rd_entry_o       (kv_rd_entry_o),
    .busy_o              (busy_o)
  );

  aes_fe_key_loader u_key_loader (
    .clk             (clk),
    .reset_n         (reset_n),
    .zeroize_i       (zeroize_i),
    .kv_rd_start_i   (kv_rd_start),
    .kv_beat_valid_i (kv_beat_valid_i),
    .kv_beat_offset_i(kv_beat_offset_i),
    .kv_beat_data_i  (kv_beat_data_i),
    .kv_done_i       (kv_done_i),
    .kv_err_i        (kv_err_i),
    .key_o           (key_o),
    .key_valid_o     (key_valid_o)
  );

  aes_fe_entropy u_entropy (
    .clk          (clk),
    .reset_n      (reset_n),
    .seed_wr_i    (seed_wr),
    .seed_idx_i   (seed_idx),
    .seed_wdata_i (seed_wdata),
    .entropy_req_i(entropy_req_i),
    .entropy_ack_o(entropy_ack_o),
    .entropy_o    (entropy_o)
  );

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/aes_fe_pkg.sv
hdl/aes_fe_req_mux.sv
hdl/aes_fe_regs.sv
hdl/aes_fe_key_loader.sv
hdl/aes_fe_entropy.sv
hdl/aes_fe_top.sv
dv/aes_fe_tb.sv
